// File: src/synth_defs.svh
`ifndef SYNTH_DEFS_SVH
`define SYNTH_DEFS_SVH

//////////////////////////////////////////////////
// strobe dividers
//////////////////////////////////////////////////

`define SAMPLE_DIV 4  // clocks per sample strobe
`define TICK_DIV   8  // clocks per envelope tick
`define NOTE_TICKS 2  // ticks per note strobe

//////////////////////////////////////////////////
// noise voice constants
//////////////////////////////////////////////////

// phase deltas indexed by note code, low to high pitch
`define NOISE_DELTA_0 32'h2000_0000
`define NOISE_DELTA_1 32'h4000_0000
`define NOISE_DELTA_2 32'h6000_0000
`define NOISE_DELTA_3 32'h8000_0000

`define LFSR_SEED 15'h7fff  // any nonzero value works

`endif

// File: src/seq_pkg.sv
`default_nettype none

package seq_pkg;

  // pattern position, 0 to 23
  typedef logic [4:0] step_idx_t;

  // selects one of the four noise pitches
  typedef logic [1:0] note_code_t;

  // note length in note strobes, stored minus one
  typedef logic [4:0] note_len_t;

  typedef logic [3:0] env_idx_t;  // envelope step, 0 to 9

endpackage

`default_nettype wire

// File: src/sound_pkg.sv
`default_nettype none

package sound_pkg;

  typedef logic [31:0] phase_delta_t;  // accumulator increment per sample

  typedef logic [8:0] env_level_t;  // unsigned amplitude

  typedef logic signed [9:0] sample_t;

  // output hold register state
  typedef enum logic {
    VOICE_EMPTY,
    VOICE_FULL
  } voice_state_e;

endpackage

`default_nettype wire

// File: src/tempo_strobes.sv
`timescale 1ns/100ps
`default_nettype none
`include "synth_defs.svh"

module tempo_strobes (
  input  logic i_clk,
  input  logic i_rst,
  output logic o_sample_stb,
  output logic o_tick_stb,
  output logic o_note_stb
);

  localparam int SAMPLE_W = $clog2(`SAMPLE_DIV);
  localparam int TICK_W   = $clog2(`TICK_DIV);
  localparam int NOTE_W   = $clog2(`NOTE_TICKS);

  localparam logic [SAMPLE_W-1:0] SAMPLE_LAST = SAMPLE_W'(`SAMPLE_DIV - 1);
  localparam logic [TICK_W-1:0]   TICK_LAST   = TICK_W'(`TICK_DIV - 1);
  localparam logic [NOTE_W-1:0]   NOTE_LAST   = NOTE_W'(`NOTE_TICKS - 1);

  logic [SAMPLE_W-1:0] r_sample_cnt;
  logic [TICK_W-1:0]   r_tick_cnt;
  logic [NOTE_W-1:0]   r_note_cnt;  // counts ticks, not clocks

  assign o_sample_stb = (r_sample_cnt == SAMPLE_LAST);
  assign o_tick_stb   = (r_tick_cnt == TICK_LAST);
  assign o_note_stb   = o_tick_stb && (r_note_cnt == NOTE_LAST);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_sample_cnt <= '0;
      r_tick_cnt   <= '0;
      r_note_cnt   <= '0;
    end else begin
      r_sample_cnt <= o_sample_stb ? '0 : r_sample_cnt + 1'b1;
      r_tick_cnt   <= o_tick_stb ? '0 : r_tick_cnt + 1'b1;
      if (o_tick_stb) begin
        r_note_cnt <= o_note_stb ? '0 : r_note_cnt + 1'b1;
      end
    end
  end

  // envelope steps change only on sample boundaries
  a_tick_on_sample: assert property (@(posedge i_clk) disable iff (i_rst)
    o_tick_stb |-> o_sample_stb);

endmodule

`default_nettype wire

// File: src/noise_note_sequencer.sv
`timescale 1ns/100ps
`default_nettype none
`include "synth_defs.svh"

module noise_note_sequencer import seq_pkg::*, sound_pkg::*; (
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_tick_stb,
  input  logic         i_note_stb,
  output phase_delta_t o_phase_delta,
  output env_level_t   o_env_level
);

  step_idx_t  r_step;
  note_len_t  r_dur_cnt;
  note_code_t s_note;
  note_len_t  s_note_len;
  logic       s_new_note;
  env_idx_t   r_env_idx;

  //////////////////////////////////////////////////
  // pattern stepping
  //////////////////////////////////////////////////

  assign s_new_note = i_note_stb && (r_dur_cnt == s_note_len);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_step    <= '0;
      r_dur_cnt <= '0;
    end else if (i_note_stb) begin
      if (s_new_note) begin
        r_dur_cnt <= '0;
        r_step    <= (r_step == 5'd23) ? '0 : r_step + 5'd1;
      end else begin
        r_dur_cnt <= r_dur_cnt + 5'd1;
      end
    end
  end

  // lengths stored minus one, so 29 holds a step for 30 note strobes
  always_comb begin
    s_note     = 2'd0;
    s_note_len = 5'd29;
    case (r_step) inside
      [5'd0:5'd3]: begin
        s_note     = 2'd0;
        s_note_len = 5'd29;
      end
      5'd4: begin
        s_note     = 2'd0;
        s_note_len = 5'd21;  // shorter kick before the fill
      end
      5'd5, 5'd7: begin
        s_note     = 2'd2;
        s_note_len = 5'd1;
      end
      5'd6, 5'd8: begin
        s_note     = 2'd1;
        s_note_len = 5'd1;
      end
      [5'd9:5'd23]: begin
        s_note_len = 5'd1;
        // 1, 3, 2, 3 repeating from step 9
        case (2'(r_step - 5'd9))
          2'd0:    s_note = 2'd1;
          2'd2:    s_note = 2'd2;
          default: s_note = 2'd3;
        endcase
      end
      default: ;
    endcase
  end

  always_comb begin
    case (s_note)
      2'd0:    o_phase_delta = `NOISE_DELTA_0;
      2'd1:    o_phase_delta = `NOISE_DELTA_1;
      2'd2:    o_phase_delta = `NOISE_DELTA_2;
      default: o_phase_delta = `NOISE_DELTA_3;
    endcase
  end

  //////////////////////////////////////////////////
  // decay envelope
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_env_idx <= '0;
    end else if (s_new_note) begin
      r_env_idx <= '0;  // wins over the coincident tick
    end else if (i_tick_stb && (r_env_idx != 4'd9)) begin
      r_env_idx <= r_env_idx + 4'd1;
    end
  end

  always_comb begin
    case (r_env_idx)
      4'd0, 4'd1, 4'd2: o_env_level = 9'd20;
      4'd3, 4'd4, 4'd5: o_env_level = 9'd12;
      4'd6, 4'd7:       o_env_level = 9'd8;
      4'd8:             o_env_level = 9'd4;
      default:          o_env_level = 9'd0;
    endcase
  end

  a_step_range: assert property (@(posedge i_clk) disable iff (i_rst)
    r_step <= 5'd23);
  a_env_range: assert property (@(posedge i_clk) disable iff (i_rst)
    r_env_idx <= 4'd9);

endmodule

`default_nettype wire

// File: src/noise_voice.sv
`timescale 1ns/100ps
`default_nettype none
`include "synth_defs.svh"

module noise_voice import sound_pkg::*; (
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_sample_stb,
  input  phase_delta_t i_phase_delta,
  input  env_level_t   i_env_level,
  input  logic         i_sample_ready,
  output sample_t      o_sample,
  output logic         o_sample_valid
);

  phase_delta_t r_phase;
  logic [32:0]  s_phase_sum;  // top bit is the overflow
  logic [14:0]  r_lfsr;
  sample_t      s_level;
  sample_t      s_next_sample;
  voice_state_e r_state;
  logic         s_load;
  logic         s_xfer;

  //////////////////////////////////////////////////
  // phase accumulator and noise LFSR
  //////////////////////////////////////////////////

  assign s_phase_sum = {1'b0, r_phase} + {1'b0, i_phase_delta};

  // keeps running under back-pressure so pitch stays in real time
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_phase <= '0;
      r_lfsr  <= `LFSR_SEED;
    end else if (i_sample_stb) begin
      r_phase <= s_phase_sum[31:0];
      if (s_phase_sum[32]) begin
        r_lfsr <= {r_lfsr[13:0], r_lfsr[14] ^ r_lfsr[13]};  // x^15+x^14+1
      end
    end
  end

  // sign from the LFSR value before this strobe's shift
  assign s_level       = sample_t'({1'b0, i_env_level});
  assign s_next_sample = r_lfsr[0] ? s_level : -s_level;

  //////////////////////////////////////////////////
  // output hold register
  //////////////////////////////////////////////////

  assign o_sample_valid = (r_state == VOICE_FULL);
  assign s_xfer         = o_sample_valid && i_sample_ready;
  assign s_load         = i_sample_stb && (!o_sample_valid || i_sample_ready);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_state <= VOICE_EMPTY;
    end else if (s_load) begin
      r_state <= VOICE_FULL;  // also covers load in the transfer cycle
    end else if (s_xfer) begin
      r_state <= VOICE_EMPTY;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s_load) begin
      o_sample <= s_next_sample;
    end
  end

  a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    o_sample_valid && !i_sample_ready |=> o_sample_valid && $stable(o_sample));
  a_lfsr_live: assert property (@(posedge i_clk) disable iff (i_rst)
    r_lfsr != '0);

endmodule

`default_nettype wire

// File: src/noise_channel_top.sv
`timescale 1ns/100ps
`default_nettype none

module noise_channel_top import sound_pkg::*; (
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_sample_ready,
  output sample_t      o_sample,
  output logic         o_sample_valid,
  output phase_delta_t o_phase_delta,
  output env_level_t   o_env_level
);

  logic         s_sample_stb;
  logic         s_tick_stb;
  logic         s_note_stb;
  phase_delta_t s_phase_delta;
  env_level_t   s_env_level;

  tempo_strobes u_strobes (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .o_sample_stb (s_sample_stb),
    .o_tick_stb   (s_tick_stb),
    .o_note_stb   (s_note_stb)
  );

  noise_note_sequencer u_sequencer (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_tick_stb    (s_tick_stb),
    .i_note_stb    (s_note_stb),
    .o_phase_delta (s_phase_delta),
    .o_env_level   (s_env_level)
  );

  noise_voice u_voice (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_sample_stb   (s_sample_stb),
    .i_phase_delta  (s_phase_delta),
    .i_env_level    (s_env_level),
    .i_sample_ready (i_sample_ready),
    .o_sample       (o_sample),
    .o_sample_valid (o_sample_valid)
  );

  // front-panel display taps
  assign o_phase_delta = s_phase_delta;
  assign o_env_level   = s_env_level;

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

// File: dv/tb_noise_channel.sv
`timescale 1ns/100ps
`default_nettype none
`include "synth_defs.svh"

module tb_noise_channel import seq_pkg::*, sound_pkg::*; ();

  localparam int CLK_PERIOD_NS = 10;
  localparam int N_TESTS = 4;
  localparam int NOTE_CODES [24] = '{0, 0, 0, 0, 0, 2, 1, 2, 1, 1, 3, 2,
                                     3, 1, 3, 2, 3, 1, 3, 2, 3, 1, 3, 2};
  localparam int ENV_LEVELS [10] = '{20, 20, 20, 12, 12, 12, 8, 8, 4, 0};

  logic         clk;
  logic         i_rst;
  logic         i_sample_ready;
  sample_t      o_sample;
  logic         o_sample_valid;
  phase_delta_t o_phase_delta;
  env_level_t   o_env_level;

  // test table
  string test_name  [N_TESTS];
  logic  test_rand  [N_TESTS];  // ready pattern, 1 = random
  int    test_count [N_TESTS];  // samples to accept

  // reference model state
  int          m_sample_cnt;
  int          m_tick_cnt;
  int          m_note_cnt;
  step_idx_t   m_step;
  int          m_dur;
  int          m_env_idx;
  logic [31:0] m_phase;
  logic [14:0] m_lfsr;
  logic        m_valid;
  sample_t     m_sample;
  int          m_wraps;

  int      seed = 32'h8a1c_5d22;
  int      accepted;
  int      dropped;
  int      checks;
  int      total_errors;
  logic    hold_wait;
  sample_t held_sample;
  longint  limit_ns;
  logic    limit_ready = 1'b0;

  tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (.o_clk(clk));

  noise_channel_top uut (
    .i_clk          (clk),
    .i_rst          (i_rst),
    .i_sample_ready (i_sample_ready),
    .o_sample       (o_sample),
    .o_sample_valid (o_sample_valid),
    .o_phase_delta  (o_phase_delta),
    .o_env_level    (o_env_level)
  );

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic int note_length(input step_idx_t step);
    if (step < 5'd4) return 30;
    if (step == 5'd4) return 22;
    return 2;
  endfunction

  function automatic phase_delta_t delta_for_code(input int code);
    case (code)
      0:       return `NOISE_DELTA_0;
      1:       return `NOISE_DELTA_1;
      2:       return `NOISE_DELTA_2;
      default: return `NOISE_DELTA_3;
    endcase
  endfunction

  // one clock edge of the channel, using pre-edge state throughout
  task automatic advance_model(input logic ready);
    logic        sample_stb;
    logic        tick_stb;
    logic        note_stb;
    logic        new_note;
    logic        load;
    logic [32:0] sum;
    int          level;
    sample_stb = (m_sample_cnt == `SAMPLE_DIV - 1);
    tick_stb   = (m_tick_cnt == `TICK_DIV - 1);
    note_stb   = tick_stb && (m_note_cnt == `NOTE_TICKS - 1);
    new_note   = note_stb && (m_dur == note_length(m_step) - 1);
    load       = sample_stb && (!m_valid || ready);
    if (sample_stb && !load) dropped++;
    if (sample_stb) begin
      level = ENV_LEVELS[m_env_idx];
      if (load) m_sample = m_lfsr[0] ? sample_t'(level) : sample_t'(-level);
      sum     = {1'b0, m_phase} + {1'b0, delta_for_code(NOTE_CODES[m_step])};
      m_phase = sum[31:0];
      if (sum[32]) m_lfsr = {m_lfsr[13:0], m_lfsr[14] ^ m_lfsr[13]};
    end
    if (load) m_valid = 1'b1;
    else if (m_valid && ready) m_valid = 1'b0;
    if (new_note) m_env_idx = 0;
    else if (tick_stb && m_env_idx < 9) m_env_idx++;
    if (note_stb && new_note) begin
      m_dur = 0;
      if (m_step == 5'd23) m_wraps++;
      m_step = (m_step == 5'd23) ? 5'd0 : m_step + 5'd1;
    end else if (note_stb) begin
      m_dur++;
    end
    m_sample_cnt = sample_stb ? 0 : m_sample_cnt + 1;
    m_tick_cnt   = tick_stb ? 0 : m_tick_cnt + 1;
    if (tick_stb) m_note_cnt = note_stb ? 0 : m_note_cnt + 1;
  endtask

  //////////////////////////////////////////////////
  // checks and drive
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input string what,
                                 input longint exp, input longint act);
    $display("CHECK FAILED %s %s: expected %0d, actual %0d", name, what, exp, act);
    total_errors++;
  endtask

  task automatic compare_outputs(input string name);
    checks++;
    if (o_sample_valid !== m_valid)
      report_mismatch(name, "o_sample_valid", longint'(m_valid), longint'(o_sample_valid));
    if (m_valid && o_sample !== m_sample)
      report_mismatch(name, "o_sample", longint'(m_sample), longint'(o_sample));
    if (hold_wait && o_sample !== held_sample)
      report_mismatch(name, "held o_sample", longint'(held_sample), longint'(o_sample));
    if (o_env_level !== env_level_t'(ENV_LEVELS[m_env_idx]))
      report_mismatch(name, "o_env_level", longint'(ENV_LEVELS[m_env_idx]),
                      longint'(o_env_level));
    if (o_phase_delta !== delta_for_code(NOTE_CODES[m_step]))
      report_mismatch(name, "o_phase_delta", longint'(delta_for_code(NOTE_CODES[m_step])),
                      longint'(o_phase_delta));
  endtask

  // called on the falling edge
  task automatic drive_and_advance(input logic random_ready);
    int rnd;
    rnd = $random(seed);
    i_sample_ready = random_ready ? rnd[0] : 1'b1;
    hold_wait      = o_sample_valid && !i_sample_ready;
    held_sample    = o_sample;
    if (o_sample_valid && i_sample_ready) accepted++;  // DUT transfer on next edge
    advance_model(i_sample_ready);
  endtask

  initial begin
    int t;
    int first_err;
    i_rst          = 1'b1;
    i_sample_ready = 1'b0;
    m_sample_cnt = 0;
    m_tick_cnt   = 0;
    m_note_cnt   = 0;
    m_step       = '0;
    m_dur        = 0;
    m_env_idx    = 0;
    m_phase      = '0;
    m_lfsr       = `LFSR_SEED;
    m_valid      = 1'b0;
    m_sample     = '0;
    m_wraps      = 0;
    hold_wait    = 1'b0;
    held_sample  = '0;
    accepted     = 0;
    checks       = 0;
    total_errors = 0;

    test_name[0]  = "env_decay";
    test_rand[0]  = 1'b0;
    test_count[0] = 130;
    test_name[1]  = "pattern_wrap";
    test_rand[1]  = 1'b0;
    test_count[1] = 760;
    test_name[2]  = "noise_samples";
    test_rand[2]  = 1'b0;
    test_count[2] = 200;
    test_name[3]  = "backpressure";
    test_rand[3]  = 1'b1;
    test_count[3] = 300;

    limit_ns = 0;
    for (t = 0; t < N_TESTS; t++) limit_ns += test_count[t];
    limit_ns = limit_ns * `SAMPLE_DIV * CLK_PERIOD_NS * 4;
    limit_ready = 1'b1;

    // reset held over two rising edges
    repeat (2) begin
      @(negedge clk);
      checks++;
      if (o_sample_valid !== 1'b0)
        report_mismatch("reset", "o_sample_valid", 0, longint'(o_sample_valid));
    end
    checks++;
    if (o_env_level !== 9'd20)
      report_mismatch("reset", "o_env_level", 20, longint'(o_env_level));
    if (o_phase_delta !== `NOISE_DELTA_0)
      report_mismatch("reset", "o_phase_delta", longint'(`NOISE_DELTA_0),
                      longint'(o_phase_delta));
    $display("test reset: %0d checks, %0d errors", checks, total_errors);
    i_rst = 1'b0;
    drive_and_advance(test_rand[0]);

    for (t = 0; t < N_TESTS; t++) begin
      first_err = total_errors;
      accepted  = 0;
      dropped   = 0;
      while (accepted < test_count[t]) begin
        @(negedge clk);
        compare_outputs(test_name[t]);
        drive_and_advance(test_rand[t]);
      end
      $display("test %s: %0d samples, %0d dropped, %0d errors", test_name[t], accepted,
               dropped, total_errors - first_err);
    end

    if (m_wraps == 0) begin
      $display("pattern never wrapped from step 23 back to step 0");
      total_errors++;
    end
    $display("tests %0d, checks %0d, errors %0d", N_TESTS + 1, checks, total_errors);
    if (total_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (limit_ready);
    #(limit_ns);
    $display("watchdog: run did not finish within %0d ns", limit_ns);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/seq_pkg.sv
src/sound_pkg.sv
src/tempo_strobes.sv
src/noise_note_sequencer.sv
src/noise_voice.sv
src/noise_channel_top.sv
dv/tb_clock.sv
dv/tb_noise_channel.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the noise channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_noise_channel -f src.f \
  --Mdir obj_dir -o sim_noise_channel
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_noise_channel 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Done: no errors"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
